// ==== common/tracker_pkg.sv ====
// Shared sizing and payload types for the out-of-order read tracker
// Used by the allocator, the metadata table and the response stage
package tracker_pkg;

    // ################################################
    // Sizing
    // ################################################

    // Default tag count, the top level may override
    localparam int unsigned NUM_TAGS_DEFAULT = 8;

    // Client request id width
    localparam int unsigned REQ_ID_W = 6;
    // Read address width
    localparam int unsigned ADDR_W   = 16;
    // Read data width
    localparam int unsigned DATA_W   = 32;

    // ################################################
    // Payload types
    // ################################################

    typedef logic [REQ_ID_W-1:0] req_id_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;

    // Stored per tag, 22 bits
    // id sits in the upper bits, address in the lower bits
    typedef struct packed {
        req_id_t req_id;
        addr_t   addr;
    } req_meta_t;

endpackage

// ==== design/tag_alloc/tag_queue.sv ====
// Tag allocator, hands out the lowest free tag first
// Tags return through the free port, used vector is exported
`timescale 1ns/1ps

module tag_queue #(
    parameter int unsigned  NUM_TAGS = 8,
    localparam int unsigned TAG_W    = $clog2(NUM_TAGS)
) (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // Release port
    input  logic                free_i,
    input  logic [TAG_W-1:0]    free_tag_i,

    // Allocation port
    input  logic                get_i,
    output logic                valid_o,
    output logic [TAG_W-1:0]    tag_o,

    // Current occupancy
    output logic [NUM_TAGS-1:0] used_o
);

    // ################################################
    // Signals
    // ################################################

    // One bit per tag, set while outstanding
    logic [NUM_TAGS-1:0] used_q;
    logic [NUM_TAGS-1:0] used_d;

    // Lowest clear bit of the current vector
    logic [TAG_W-1:0]    free_idx;
    logic                any_free;

    // ################################################
    // Lowest free search
    // ################################################

    always_comb begin
        free_idx = '0;
        any_free = 1'b0;
        // Scan from the top down so the lowest index wins
        for (int i = NUM_TAGS - 1; i >= 0; i--) begin
            if (!used_q[i]) begin
                free_idx = TAG_W'(i);
                any_free = 1'b1;
            end
        end
    end

    // Ready while at least one tag is clear
    assign valid_o = any_free;

    // Tag is zero unless a grant happens
    assign tag_o   = (get_i && valid_o) ? free_idx : '0;

    // ################################################
    // Next state
    // ################################################

    always_comb begin
        used_d = used_q;
        // Release, tag reusable from the next cycle on
        if (free_i) begin
            used_d[free_tag_i] = 1'b0;
        end
        // Grant works on used_q, never hits a tag freed this cycle
        if (get_i && valid_o) begin
            used_d[free_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // All tags free after reset
            used_q <= '0;
        end else begin
            used_q <= used_d;
        end
    end

    // Raw register view for the response stage
    assign used_o = used_q;

endmodule

// ==== design/tag_alloc/tag_meta_table.sv ====
// Per-tag metadata store, request id and address
// Written on allocation, read combinationally by response tag
`timescale 1ns/1ps

module tag_meta_table #(
    parameter int unsigned  NUM_TAGS = 8,
    localparam int unsigned TAG_W    = $clog2(NUM_TAGS)
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Write side, from the accepted request
    input  logic                  wr_en_i,
    input  logic [TAG_W-1:0]      wr_tag_i,
    input  tracker_pkg::req_meta_t wr_meta_i,

    // Read side, indexed by the response tag
    input  logic [TAG_W-1:0]      rd_tag_i,
    output tracker_pkg::req_meta_t rd_meta_o
);

    // ################################################
    // Storage
    // ################################################

    tracker_pkg::req_meta_t meta_q [NUM_TAGS];

    // One cycle write latency
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_TAGS; i++) begin
                meta_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            meta_q[wr_tag_i] <= wr_meta_i;
        end
    end

    // ################################################
    // Read port
    // ################################################

    // Same cycle lookup
    // Out of range tags read as zero when NUM_TAGS is not a power of two
    always_comb begin
        rd_meta_o = '0;
        if (32'(rd_tag_i) < NUM_TAGS) begin
            rd_meta_o = meta_q[rd_tag_i];
        end
    end

endmodule

// ==== design/rsp_merge.sv ====
// Response stage, checks the tag, frees it and registers the completion
// Unknown tags turn into a one-cycle error pulse
`timescale 1ns/1ps

module rsp_merge #(
    parameter int unsigned  NUM_TAGS = 8,
    localparam int unsigned TAG_W    = $clog2(NUM_TAGS)
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    // Memory response
    input  logic                   rsp_i,
    input  logic [TAG_W-1:0]       rsp_tag_i,
    input  tracker_pkg::data_t     rsp_data_i,

    // Allocator state and table lookup
    input  logic [NUM_TAGS-1:0]    used_i,
    input  tracker_pkg::req_meta_t meta_i,

    // Release strobe into the allocator
    output logic                   free_o,
    output logic [TAG_W-1:0]       free_tag_o,

    // Completion, one cycle after the response
    output logic                   cpl_valid_o,
    output logic                   cpl_err_o,
    output tracker_pkg::req_id_t   cpl_id_o,
    output tracker_pkg::addr_t     cpl_addr_o,
    output tracker_pkg::data_t     cpl_data_o
);

    // ################################################
    // Tag check
    // ################################################

    logic tag_ok;

    // Tag must be in range and currently outstanding
    assign tag_ok = (32'(rsp_tag_i) < NUM_TAGS) && used_i[rsp_tag_i];

    // Release in the response cycle itself
    assign free_o     = rsp_i && tag_ok;
    assign free_tag_o = rsp_tag_i;

    // ################################################
    // Completion register
    // ################################################

    // Strobes, cleared on reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cpl_valid_o <= 1'b0;
            cpl_err_o   <= 1'b0;
        end else begin
            cpl_valid_o <= rsp_i && tag_ok;
            cpl_err_o   <= rsp_i && !tag_ok;
        end
    end

    // Payload, loaded on every response
    always_ff @(posedge clk_i) begin
        if (rsp_i) begin
            cpl_data_o <= rsp_data_i;
            if (tag_ok) begin
                cpl_id_o   <= meta_i.req_id;
                cpl_addr_o <= meta_i.addr;
            end else begin
                // Error carries data only
                cpl_id_o   <= '0;
                cpl_addr_o <= '0;
            end
        end
    end

endmodule

// ==== design/req_tracker_top.sv ====
// Outstanding read tracker for a memory port with out-of-order responses
// Ties the tag allocator, the metadata table and the response stage together
`timescale 1ns/1ps

module req_tracker_top #(
    parameter int unsigned  NUM_TAGS = tracker_pkg::NUM_TAGS_DEFAULT,
    localparam int unsigned TAG_W    = $clog2(NUM_TAGS)
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Client request
    input  logic                 req_i,
    input  tracker_pkg::req_id_t req_id_i,
    input  tracker_pkg::addr_t   req_addr_i,
    output logic                 ready_o,

    // Memory request
    output logic                 mem_req_o,
    output logic [TAG_W-1:0]     mem_tag_o,
    output tracker_pkg::addr_t   mem_addr_o,

    // Memory response
    input  logic                 rsp_i,
    input  logic [TAG_W-1:0]     rsp_tag_i,
    input  tracker_pkg::data_t   rsp_data_i,

    // Completion
    output logic                 cpl_valid_o,
    output logic                 cpl_err_o,
    output tracker_pkg::req_id_t cpl_id_o,
    output tracker_pkg::addr_t   cpl_addr_o,
    output tracker_pkg::data_t   cpl_data_o
);

    // ################################################
    // Internal wiring
    // ################################################

    logic                   accept;
    logic [TAG_W-1:0]       alloc_tag;
    logic [NUM_TAGS-1:0]    used_vec;
    logic                   free_stb;
    logic [TAG_W-1:0]       free_tag;
    tracker_pkg::req_meta_t wr_meta;
    tracker_pkg::req_meta_t rd_meta;

    // Request only counts while a tag is free
    assign accept         = req_i && ready_o;

    // Pack the stored payload
    assign wr_meta.req_id = req_id_i;
    assign wr_meta.addr   = req_addr_i;

    // Downstream request in the accepting cycle
    assign mem_req_o  = accept;
    assign mem_tag_o  = alloc_tag;
    assign mem_addr_o = req_addr_i;

    // ################################################
    // Allocator
    // ################################################

    tag_queue #(
        .NUM_TAGS(NUM_TAGS)
    ) u_tag_queue (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .free_i    (free_stb),
        .free_tag_i(free_tag),
        .get_i     (accept),
        .valid_o   (ready_o),
        .tag_o     (alloc_tag),
        .used_o    (used_vec)
    );

    // Metadata, written at the allocated tag
    tag_meta_table #(
        .NUM_TAGS(NUM_TAGS)
    ) u_tag_meta_table (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wr_en_i  (accept),
        .wr_tag_i (alloc_tag),
        .wr_meta_i(wr_meta),
        .rd_tag_i (rsp_tag_i),
        .rd_meta_o(rd_meta)
    );

    // ################################################
    // Response stage
    // ################################################

    rsp_merge #(
        .NUM_TAGS(NUM_TAGS)
    ) u_rsp_merge (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rsp_i      (rsp_i),
        .rsp_tag_i  (rsp_tag_i),
        .rsp_data_i (rsp_data_i),
        .used_i     (used_vec),
        .meta_i     (rd_meta),
        .free_o     (free_stb),
        .free_tag_o (free_tag),
        .cpl_valid_o(cpl_valid_o),
        .cpl_err_o  (cpl_err_o),
        .cpl_id_o   (cpl_id_o),
        .cpl_addr_o (cpl_addr_o),
        .cpl_data_o (cpl_data_o)
    );

endmodule

// ==== sim/tracker_checker.sv ====
// Protocol assertions for the read tracker
// Bound into the top level, watches the request and completion strobes
`timescale 1ns/1ps

module tracker_checker (
    input logic clk_i,
    input logic rst_n_i,
    input logic ready_i,
    input logic mem_req_i,
    input logic rsp_i,
    input logic cpl_valid_i,
    input logic cpl_err_i
);

    // Failed assertions so far, summed into the final verdict
    int fail_count = 0;

    // ################################################
    // Request side
    // ################################################

    // No downstream request without a free tag
    req_needs_ready: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mem_req_i |-> ready_i
    ) else begin
        $error("mem_req_o high while ready_o is low");
        fail_count++;
    end

    // ################################################
    // Completion side
    // ################################################

    // Good and bad completions exclude each other
    cpl_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(cpl_valid_i && cpl_err_i)
    ) else begin
        $error("cpl_valid_o and cpl_err_o high together");
        fail_count++;
    end

    // One completion cycle per response, none without one
    cpl_single_cycle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !rsp_i |=> !(cpl_valid_i || cpl_err_i)
    ) else begin
        $error("completion pulse longer than its response");
        fail_count++;
    end

endmodule

bind req_tracker_top tracker_checker u_tracker_checker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ready_i    (ready_o),
    .mem_req_i  (mem_req_o),
    .rsp_i      (rsp_i),
    .cpl_valid_i(cpl_valid_o),
    .cpl_err_i  (cpl_err_o)
);

// ==== sim/tb_req_tracker.sv ====
// Testbench for the out-of-order read tracker
// Table-driven steps checked against a lowest-free-first tag model
`timescale 1ns/1ps

module tb_req_tracker;

    localparam int unsigned NUM_TAGS     = 8;
    localparam int unsigned TAG_W        = $clog2(NUM_TAGS);
    localparam int unsigned RST_CYCLES   = 16;
    localparam int unsigned STEP_TIMEOUT = 10;

    // Step kinds
    localparam int KIND_REQ = 0;
    localparam int KIND_RSP = 1;
    localparam int KIND_BAD = 2;

    logic                 clk;
    logic                 rst_n;
    logic                 req;
    tracker_pkg::req_id_t req_id;
    tracker_pkg::addr_t   req_addr;
    logic                 ready;
    logic                 mem_req;
    logic [TAG_W-1:0]     mem_tag;
    tracker_pkg::addr_t   mem_addr;
    logic                 rsp;
    logic [TAG_W-1:0]     rsp_tag;
    tracker_pkg::data_t   rsp_data;
    logic                 cpl_valid;
    logic                 cpl_err;
    tracker_pkg::req_id_t cpl_id;
    tracker_pkg::addr_t   cpl_addr;
    tracker_pkg::data_t   cpl_data;

    // ################################################
    // Step table, model state, counters
    // ################################################

    // ok column: acceptance for requests, cpl_valid_o for responses
    int                   step_kind [$];
    logic                 step_ok   [$];
    tracker_pkg::req_id_t step_id   [$];
    tracker_pkg::addr_t   step_addr [$];
    tracker_pkg::data_t   step_data [$];
    int                   n_steps;

    // Reference copy of the outstanding tags
    logic [NUM_TAGS-1:0]  model_used;
    tracker_pkg::req_id_t model_id   [NUM_TAGS];
    tracker_pkg::addr_t   model_addr [NUM_TAGS];

    logic [15:0]          lfsr;
    int                   value_errors;
    int                   other_errors;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    req_tracker_top #(
        .NUM_TAGS(NUM_TAGS)
    ) uut (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .req_i      (req),
        .req_id_i   (req_id),
        .req_addr_i (req_addr),
        .ready_o    (ready),
        .mem_req_o  (mem_req),
        .mem_tag_o  (mem_tag),
        .mem_addr_o (mem_addr),
        .rsp_i      (rsp),
        .rsp_tag_i  (rsp_tag),
        .rsp_data_i (rsp_data),
        .cpl_valid_o(cpl_valid),
        .cpl_err_o  (cpl_err),
        .cpl_id_o   (cpl_id),
        .cpl_addr_o (cpl_addr),
        .cpl_data_o (cpl_data)
    );

    // ################################################
    // Compare tasks
    // ################################################

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s: got %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_tag(input logic [TAG_W-1:0] got, input logic [TAG_W-1:0] exp,
                             input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_id(input tracker_pkg::req_id_t got, input tracker_pkg::req_id_t exp,
                            input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input tracker_pkg::addr_t got, input tracker_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input tracker_pkg::data_t got, input tracker_pkg::data_t exp,
                              input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // ################################################
    // Model helpers and LFSR
    // ################################################

    // Lowest clear tag, -1 when all are taken
    function automatic int lowest_free();
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (!model_used[i]) return i;
        end
        return -1;
    endfunction

    // Highest clear tag, used as the bogus response tag
    function automatic int highest_free();
        for (int i = NUM_TAGS - 1; i >= 0; i--) begin
            if (!model_used[i]) return i;
        end
        return -1;
    endfunction

    // k-th outstanding tag, counted upward
    function automatic int nth_used(input int k);
        int seen;
        seen = 0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (model_used[i]) begin
                if (seen == k) return i;
                seen++;
            end
        end
        return -1;
    endfunction

    // Galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = {1'b0, s[15:1]};
        if (s[0]) n = n ^ 16'hB400;
        return n;
    endfunction

    // One LFSR step per bit taken
    function automatic int draw_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return val;
    endfunction

    task automatic add_step(input int kind, input logic ok, input tracker_pkg::req_id_t id,
                            input tracker_pkg::addr_t addr, input tracker_pkg::data_t data);
        step_kind.push_back(kind);
        step_ok.push_back(ok);
        step_id.push_back(id);
        step_addr.push_back(addr);
        step_data.push_back(data);
    endtask

    task automatic load_table();
        // Fill every tag, expect tags 0 upward
        for (int i = 0; i < NUM_TAGS; i++) begin
            add_step(KIND_REQ, 1'b1, tracker_pkg::req_id_t'(i + 1),
                     tracker_pkg::addr_t'(32'h1000 + i * 16), '0);
        end
        // Full, must be ignored
        add_step(KIND_REQ, 1'b0, 6'h3f, 16'hdead, '0);
        for (int i = 0; i < 3; i++) add_step(KIND_RSP, 1'b1, '0, '0, 32'hc0de_0000 + i);
        // Refill freed tags
        add_step(KIND_REQ, 1'b1, 6'h11, 16'h2000, '0);
        add_step(KIND_REQ, 1'b1, 6'h12, 16'h2010, '0);
        add_step(KIND_BAD, 1'b0, '0, '0, 32'hbad0_0001);
        add_step(KIND_REQ, 1'b1, 6'h13, 16'h2020, '0);
        add_step(KIND_REQ, 1'b0, 6'h14, 16'h2030, '0);
        for (int i = 0; i < 5; i++) add_step(KIND_RSP, 1'b1, '0, '0, 32'h5a5a_0100 + i);
        add_step(KIND_BAD, 1'b0, '0, '0, 32'hbad0_0002);
        for (int i = 0; i < 3; i++) begin
            add_step(KIND_REQ, 1'b1, tracker_pkg::req_id_t'(i + 32),
                     tracker_pkg::addr_t'(32'h3000 + i * 4), '0);
        end
        for (int i = 0; i < 6; i++) add_step(KIND_RSP, 1'b1, '0, '0, 32'h0f0f_0200 + i);
        add_step(KIND_BAD, 1'b0, '0, '0, 32'hbad0_0003);
        add_step(KIND_REQ, 1'b1, 6'h2a, 16'h4000, '0);
        add_step(KIND_REQ, 1'b1, 6'h2b, 16'h4004, '0);
        for (int i = 0; i < 2; i++) add_step(KIND_RSP, 1'b1, '0, '0, 32'h7777_0300 + i);
    endtask

    // ################################################
    // Step tasks, entered on a falling edge
    // ################################################

    task automatic do_request(input logic exp_ok, input tracker_pkg::req_id_t id,
                              input tracker_pkg::addr_t addr);
        int tag;
        tag = lowest_free();
        if ((tag >= 0) != exp_ok) begin
            other_errors++;
            $display("Table step disagrees with the model on request acceptance");
        end
        req      = 1'b1;
        req_id   = id;
        req_addr = addr;
        #1;
        check_bit(ready, exp_ok, "ready_o");
        check_bit(mem_req, exp_ok, "mem_req_o");
        if (tag >= 0) begin
            check_tag(mem_tag, TAG_W'(tag), "mem_tag_o");
            check_addr(mem_addr, addr, "mem_addr_o");
        end else begin
            check_tag(mem_tag, '0, "mem_tag_o while refused");
        end
        @(negedge clk);
        req = 1'b0;
        if (tag >= 0 && exp_ok) begin
            model_used[tag] = 1'b1;
            model_id[tag]   = id;
            model_addr[tag] = addr;
        end
        // Nothing completes without a response
        check_bit(cpl_valid, 1'b0, "cpl_valid_o after request");
        check_bit(cpl_err, 1'b0, "cpl_err_o after request");
    endtask

    task automatic do_response(input int kind, input logic exp_valid,
                               input tracker_pkg::data_t data);
        int count;
        int tag;
        count = $countones(model_used);
        if (kind == KIND_RSP) begin
            tag = (count > 0) ? nth_used(draw_bits(TAG_W) % count) : -1;
        end else begin
            tag = highest_free();
        end
        if (tag < 0) begin
            other_errors++;
            $display("No suitable tag exists for a response step in the table");
            return;
        end
        rsp      = 1'b1;
        rsp_tag  = TAG_W'(tag);
        rsp_data = data;
        #1;
        check_bit(mem_req, 1'b0, "mem_req_o during response");
        @(negedge clk);
        rsp = 1'b0;
        check_bit(cpl_valid, exp_valid, "cpl_valid_o");
        check_bit(cpl_err, !exp_valid, "cpl_err_o");
        check_data(cpl_data, data, "cpl_data_o");
        if (exp_valid) begin
            check_id(cpl_id, model_id[tag], "cpl_id_o");
            check_addr(cpl_addr, model_addr[tag], "cpl_addr_o");
            model_used[tag] = 1'b0;
        end else begin
            check_id(cpl_id, '0, "cpl_id_o on error");
            check_addr(cpl_addr, '0, "cpl_addr_o on error");
        end
    endtask

    // ################################################
    // Main sequence and watchdog
    // ################################################

    initial begin
        rst_n        = 1'b0;
        req          = 1'b0;
        req_id       = '0;
        req_addr     = '0;
        rsp          = 1'b0;
        rsp_tag      = '0;
        rsp_data     = '0;
        lfsr         = 16'd2998;
        value_errors = 0;
        other_errors = 0;
        model_used   = '0;
        load_table();
        n_steps = step_kind.size();
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // Idle state after reset
        check_bit(ready, 1'b1, "ready_o after reset");
        check_bit(mem_req, 1'b0, "mem_req_o after reset");
        check_bit(cpl_valid, 1'b0, "cpl_valid_o after reset");
        check_bit(cpl_err, 1'b0, "cpl_err_o after reset");
        for (int i = 0; i < n_steps; i++) begin
            if (step_kind[i] == KIND_REQ) begin
                do_request(step_ok[i], step_id[i], step_addr[i]);
            end else begin
                do_response(step_kind[i], step_ok[i], step_data[i]);
            end
        end
        $display("Errors: %0d value mismatches, %0d assertion failures, %0d other",
                 value_errors, uut.u_tracker_checker.fail_count, other_errors);
        if (value_errors + other_errors + uut.u_tracker_checker.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Budget of ten cycles per step on top of reset
    initial begin
        wait (n_steps > 0);
        repeat (RST_CYCLES + n_steps * STEP_TIMEOUT) @(posedge clk);
        $display("Timeout: the watchdog expired before the step table finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
common/tracker_pkg.sv
design/tag_alloc/tag_queue.sv
design/tag_alloc/tag_meta_table.sv
design/rsp_merge.sv
design/req_tracker_top.sv
sim/tracker_checker.sv
sim/tb_req_tracker.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tracker testbench with Verilator
# Fails when the log holds the fail message or the run aborts

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_req_tracker \
    -f flist.f \
    -o tb_req_tracker \
    > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_req_tracker > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation ended with an error"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && { echo "Test failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "No pass line in sim.log"; exit 1; }
echo "Test passed"
